// File: hw/aes_pkg.sv
package aes_pkg;

  typedef logic [127:0] block_t;  // Column-major, byte 0 in the top bits
  typedef logic [31:0]  word_t;
  typedef logic [7:0]   byte_t;
  typedef logic [3:0]   round_t;
  typedef logic [7:0]   addr_t;

  localparam round_t NUM_ROUNDS = 4'd10;

  // Register map
  localparam addr_t ADDR_CTRL   = 8'h00;  // Bit 0 start, bit 1 key load
  localparam addr_t ADDR_STATUS = 8'h04;  // Bit 0 busy, bit 1 key_ready, bit 2 done
  localparam addr_t ADDR_KEY0   = 8'h10;  // Word 0 is the key MSW
  localparam addr_t ADDR_DIN0   = 8'h20;
  localparam addr_t ADDR_DOUT0  = 8'h30;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef struct packed {
    logic  awvalid;
    addr_t awaddr;
    logic  wvalid;
    word_t wdata;
    logic  bready;
    logic  arvalid;
    addr_t araddr;
    logic  rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    word_t      rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic key_load;  // Copy the user key into the schedule
    logic key_fwd;   // One forward key step
    logic key_inv;   // One inverse key step
    logic blk_load;  // Initial AddRoundKey
    logic rnd_step;
    logic rnd_last;  // No InvMixColumns
  } ctl_t;

  typedef enum logic [1:0] {
    IDLE,
    EXPAND,
    DECRYPT
  } dec_state_e;

  // FIPS-197 tables, entry 0 in the top byte
  localparam logic [2047:0] SBOX_TBL = {
    256'h637c777bf26b6fc53001672bfed7ab76_ca82c97dfa5947f0add4a2af9ca472c0,
    256'hb7fd9326363ff7cc34a5e5f171d83115_04c723c31896059a071280e2eb27b275,
    256'h09832c1a1b6e5aa0523bd6b329e32f84_53d100ed20fcb15b6acbbe394a4c58cf,
    256'hd0efaafb434d338545f9027f503c9fa8_51a3408f929d38f5bcb6da2110fff3d2,
    256'hcd0c13ec5f974417c4a77e3d645d1973_60814fdc222a908846eeb814de5e0bdb,
    256'he0323a0a4906245cc2d3ac629195e479_e7c8376d8dd54ea96c56f4ea657aae08,
    256'hba78252e1ca6b4c6e8dd741f4bbd8b8a_703eb5664803f60e613557b986c11d9e,
    256'he1f8981169d98e949b1e87e9ce5528df_8ca1890dbfe6426841992d0fb054bb16
  };

  localparam logic [2047:0] INV_SBOX_TBL = {
    256'h52096ad53036a538bf40a39e81f3d7fb_7ce339829b2fff87348e4344c4dee9cb,
    256'h547b9432a6c2233dee4c950b42fac34e_082ea16628d924b2765ba2496d8bd125,
    256'h72f8f66486689816d4a45ccc5d65b692_6c704850fdedb9da5e154657a78d9d84,
    256'h90d8ab008cbcd30af7e45805b8b34506_d02c1e8fca3f0f02c1afbd0301138a6b,
    256'h3a9111414f67dcea97f2cfcef0b4e673_96ac7422e7ad3585e2f937e81c75df6e,
    256'h47f11a711d29c5896fb7620eaa18be1b_fc563e4bc6d279209adbc0fe78cd5af4,
    256'h1fdda8338807c731b11210592780ec5f_60517fa919b54a0d2de57a9f93c99cef,
    256'ha0e03b4dae2af5b0c8ebbb3c83539961_172b047eba77d626e169146355210c7d
  };

  function automatic byte_t sbox(input byte_t b);
    return SBOX_TBL[2047 - 8 * int'(b) -: 8];
  endfunction

  function automatic byte_t inv_sbox(input byte_t b);
    return INV_SBOX_TBL[2047 - 8 * int'(b) -: 8];
  endfunction

  function automatic byte_t xtime(input byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Shift-and-add multiply in GF(2^8)
  function automatic byte_t gf_mul(input byte_t a, input byte_t b);
    byte_t acc;
    byte_t p;
    acc = '0;
    p = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) acc ^= p;
      p = xtime(p);
    end
    return acc;
  endfunction

  function automatic byte_t rcon(input round_t r);
    case (r)
      4'd1:    return 8'h01;
      4'd2:    return 8'h02;
      4'd3:    return 8'h04;
      4'd4:    return 8'h08;
      4'd5:    return 8'h10;
      4'd6:    return 8'h20;
      4'd7:    return 8'h40;
      4'd8:    return 8'h80;
      4'd9:    return 8'h1b;
      4'd10:   return 8'h36;
      default: return 8'h00;
    endcase
  endfunction

endpackage

// File: hw/aes_axil_regs.sv
module aes_axil_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  aes_pkg::axil_req_t axil_req,
  output aes_pkg::axil_rsp_t axil_rsp,
  input  logic               busy,
  input  logic               key_ready,
  input  logic               done,
  input  aes_pkg::block_t    dout,
  output logic               start,
  output logic               key_go,
  output aes_pkg::block_t    key_word,
  output aes_pkg::block_t    din
);

  logic                 aw_rdy_q;
  logic                 bvalid_q;
  logic                 ar_rdy_q;
  logic                 rvalid_q;
  aes_pkg::word_t       rdata_q;
  aes_pkg::word_t       rd_word;
  aes_pkg::word_t [0:3] key_q;  // Index 0 is the most significant word
  aes_pkg::word_t [0:3] din_q;
  aes_pkg::word_t [0:3] dout_w;
  logic                 wr_en;
  logic                 rd_en;
  logic                 ctrl_wr;
  logic [1:0]           wr_idx;
  logic [1:0]           rd_idx;

  assign wr_en   = aw_rdy_q && axil_req.awvalid && axil_req.wvalid;
  assign rd_en   = ar_rdy_q && axil_req.arvalid;
  assign ctrl_wr = wr_en && (axil_req.awaddr == aes_pkg::ADDR_CTRL);
  assign wr_idx  = axil_req.awaddr[3:2];
  assign rd_idx  = axil_req.araddr[3:2];

  assign key_word = key_q;
  assign din      = din_q;
  assign dout_w   = dout;

  // Write channel, one outstanding response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aw_rdy_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      aw_rdy_q <= axil_req.awvalid && axil_req.wvalid && !bvalid_q && !aw_rdy_q;
      if (wr_en) begin
        bvalid_q <= 1'b1;
      end else if (bvalid_q && axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_q  <= '0;
      din_q  <= '0;
      start  <= 1'b0;
      key_go <= 1'b0;
    end else begin
      start  <= ctrl_wr && axil_req.wdata[0];  // Single-cycle pulses
      key_go <= ctrl_wr && axil_req.wdata[1];
      if (wr_en && !busy) begin  // Operands are frozen during a run
        if (axil_req.awaddr[7:4] == aes_pkg::ADDR_KEY0[7:4]) begin
          key_q[wr_idx] <= axil_req.wdata;
        end
        if (axil_req.awaddr[7:4] == aes_pkg::ADDR_DIN0[7:4]) begin
          din_q[wr_idx] <= axil_req.wdata;
        end
      end
    end
  end

  // Read decode; key words are write-only
  always_comb begin
    rd_word = '0;
    if (axil_req.araddr == aes_pkg::ADDR_STATUS) begin
      rd_word = {29'd0, done, key_ready, busy};
    end else if (axil_req.araddr[7:4] == aes_pkg::ADDR_DIN0[7:4]) begin
      rd_word = din_q[rd_idx];
    end else if (axil_req.araddr[7:4] == aes_pkg::ADDR_DOUT0[7:4]) begin
      rd_word = dout_w[rd_idx];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_rdy_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      ar_rdy_q <= axil_req.arvalid && !rvalid_q && !ar_rdy_q;
      if (rd_en) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata_q <= rd_word;  // Held until the next accepted read
    end
  end

  always_comb begin
    axil_rsp.awready = aw_rdy_q;
    axil_rsp.wready  = aw_rdy_q;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = aes_pkg::RESP_OKAY;
    axil_rsp.arready = ar_rdy_q;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = aes_pkg::RESP_OKAY;
  end

endmodule

// File: hw/aes_dec_ctrl.sv
module aes_dec_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  logic              key_go,
  output aes_pkg::ctl_t     ctl,
  output aes_pkg::round_t   round,
  output logic              busy,
  output logic              key_ready,
  output logic              done
);

  aes_pkg::dec_state_e state_q;
  aes_pkg::round_t     round_q;
  logic                key_ready_q;
  logic                done_q;
  logic                do_key;
  logic                do_blk;

  // Key load wins over a start in the same write
  assign do_key = key_go && (state_q == aes_pkg::IDLE);
  assign do_blk = start && !key_go && key_ready_q && (state_q == aes_pkg::IDLE);

  always_comb begin
    ctl.key_load = do_key;
    ctl.key_fwd  = (state_q == aes_pkg::EXPAND);
    ctl.key_inv  = (state_q == aes_pkg::DECRYPT);
    ctl.blk_load = do_blk;
    ctl.rnd_step = (state_q == aes_pkg::DECRYPT);
    ctl.rnd_last = (state_q == aes_pkg::DECRYPT) && (round_q == 4'd1);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= aes_pkg::IDLE;
      round_q     <= '0;
      key_ready_q <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      case (state_q)
        aes_pkg::IDLE: begin
          if (do_key) begin
            state_q     <= aes_pkg::EXPAND;
            round_q     <= 4'd1;
            key_ready_q <= 1'b0;  // Old last round key is gone
          end else if (do_blk) begin
            state_q <= aes_pkg::DECRYPT;
            round_q <= aes_pkg::NUM_ROUNDS;
            done_q  <= 1'b0;
          end
        end
        aes_pkg::EXPAND: begin
          if (round_q == aes_pkg::NUM_ROUNDS) begin
            state_q     <= aes_pkg::IDLE;
            key_ready_q <= 1'b1;
          end else begin
            round_q <= round_q + 4'd1;
          end
        end
        aes_pkg::DECRYPT: begin
          round_q <= round_q - 4'd1;  // Ends at 0
          if (round_q == 4'd1) begin
            state_q <= aes_pkg::IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= aes_pkg::IDLE;
      endcase
    end
  end

  assign round     = round_q;
  assign busy      = (state_q != aes_pkg::IDLE);
  assign key_ready = key_ready_q;
  assign done      = done_q;

endmodule

// File: hw/aes_inv_round.sv
module aes_inv_round (
  input  logic            clk,
  input  logic            rst_n,
  input  aes_pkg::ctl_t   ctl,
  input  aes_pkg::block_t din,
  input  aes_pkg::block_t round_key,
  output aes_pkg::block_t dout
);

  aes_pkg::byte_t [0:15] state_q;  // Byte 4*c + r is row r of column c
  aes_pkg::byte_t [0:15] shifted;
  aes_pkg::byte_t [0:15] subbed;
  aes_pkg::word_t [0:3]  keyed;
  aes_pkg::word_t [0:3]  mixed;

  // One column of InvMixColumns, circulant rows of {0e, 0b, 0d, 09}
  function automatic aes_pkg::word_t inv_mix_col(input aes_pkg::word_t col);
    aes_pkg::byte_t [0:3] a;
    aes_pkg::byte_t [0:3] coef;
    aes_pkg::byte_t [0:3] m;
    a = col;
    coef = {8'h0e, 8'h0b, 8'h0d, 8'h09};
    m = '0;
    for (int r = 0; r < 4; r++) begin
      for (int k = 0; k < 4; k++) begin
        m[r] ^= aes_pkg::gf_mul(a[k], coef[(k - r + 4) % 4]);
      end
    end
    return m;
  endfunction

  always_comb begin
    // InvShiftRows rotates row r right by r
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted[4 * c + r] = state_q[4 * ((c - r + 4) % 4) + r];
      end
    end
    for (int i = 0; i < 16; i++) begin
      subbed[i] = aes_pkg::inv_sbox(shifted[i]);
    end
    keyed = subbed ^ round_key;
    for (int c = 0; c < 4; c++) begin
      mixed[c] = inv_mix_col(keyed[c]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= '0;
    end else if (ctl.blk_load) begin
      state_q <= din ^ round_key;  // Initial AddRoundKey with the last key
    end else if (ctl.rnd_step) begin
      state_q <= ctl.rnd_last ? keyed : mixed;
    end
  end

  assign dout = state_q;

endmodule

// File: hw/aes_key_sched.sv
module aes_key_sched (
  input  logic            clk,
  input  logic            rst_n,
  input  aes_pkg::ctl_t   ctl,
  input  aes_pkg::round_t round,
  input  aes_pkg::block_t key_word,
  output aes_pkg::block_t round_key
);

  aes_pkg::word_t [0:3] work_q;  // Current round key, w0 first
  aes_pkg::word_t [0:3] last_q;  // Round 10 key, kept between blocks
  aes_pkg::word_t [0:3] fwd_w;
  aes_pkg::word_t [0:3] inv_w;
  aes_pkg::word_t       rc;

  // RotWord then SubWord
  function automatic aes_pkg::word_t sub_rot(input aes_pkg::word_t w);
    return {aes_pkg::sbox(w[23:16]), aes_pkg::sbox(w[15:8]),
            aes_pkg::sbox(w[7:0]), aes_pkg::sbox(w[31:24])};
  endfunction

  always_comb begin
    rc = {aes_pkg::rcon(round), 24'h0};

    // K(r-1) to K(r)
    fwd_w[0] = work_q[0] ^ sub_rot(work_q[3]) ^ rc;
    fwd_w[1] = work_q[1] ^ fwd_w[0];
    fwd_w[2] = work_q[2] ^ fwd_w[1];
    fwd_w[3] = work_q[3] ^ fwd_w[2];

    // K(r) back to K(r-1), last word first
    inv_w[3] = work_q[3] ^ work_q[2];
    inv_w[2] = work_q[2] ^ work_q[1];
    inv_w[1] = work_q[1] ^ work_q[0];
    inv_w[0] = work_q[0] ^ sub_rot(inv_w[3]) ^ rc;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      work_q <= '0;
      last_q <= '0;
    end else begin
      if (ctl.key_load) begin
        work_q <= key_word;
      end else if (ctl.key_fwd) begin
        work_q <= fwd_w;
      end else if (ctl.blk_load) begin
        work_q <= last_q;  // Restart the walk from round 10
      end else if (ctl.key_inv) begin
        work_q <= inv_w;
      end
      if (ctl.key_fwd && (round == aes_pkg::NUM_ROUNDS)) begin
        last_q <= fwd_w;
      end
    end
  end

  // Same-cycle key for the initial AddRoundKey and each round
  assign round_key = ctl.blk_load ? last_q : inv_w;

endmodule

// File: hw/aes_dec_top.sv
module aes_dec_top (
  input  logic               clk,
  input  logic               rst_n,
  input  aes_pkg::axil_req_t axil_req,
  output aes_pkg::axil_rsp_t axil_rsp
);

  logic            start;
  logic            key_go;
  logic            busy;
  logic            key_ready;
  logic            done;
  aes_pkg::ctl_t   ctl;
  aes_pkg::round_t round;
  aes_pkg::block_t key_word;
  aes_pkg::block_t din;
  aes_pkg::block_t dout;
  aes_pkg::block_t round_key;

  aes_axil_regs aes_axil_regs_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .busy      (busy),
    .key_ready (key_ready),
    .done      (done),
    .dout      (dout),
    .start     (start),
    .key_go    (key_go),
    .key_word  (key_word),
    .din       (din)
  );

  aes_dec_ctrl aes_dec_ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .key_go    (key_go),
    .ctl       (ctl),
    .round     (round),
    .busy      (busy),
    .key_ready (key_ready),
    .done      (done)
  );

  aes_key_sched aes_key_sched_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctl       (ctl),
    .round     (round),
    .key_word  (key_word),
    .round_key (round_key)
  );

  aes_inv_round aes_inv_round_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctl       (ctl),
    .din       (din),
    .round_key (round_key),
    .dout      (dout)
  );

endmodule

// File: tb/aes_dec_props.sv
module aes_dec_props (
  input logic               clk,
  input logic               rst_n,
  input aes_pkg::axil_req_t axil_req,
  input aes_pkg::axil_rsp_t axil_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  // Write response held until taken
  bvalid_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid
  ) else $error("bvalid dropped before bready");

  rvalid_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata)
  ) else $error("rvalid or rdata changed before rready");

  // No new write while a response is pending
  no_aw_in_b: assert property (
    @(posedge clk) disable iff (!rst_n)
    axil_rsp.bvalid |-> !axil_rsp.awready
  ) else $error("awready high while bvalid pending");

endmodule

// File: tb/aes_dec_tb.sv
module aes_dec_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    aes_pkg::block_t key;
    aes_pkg::block_t ct;
    aes_pkg::block_t pt;
  } vec_t;

  localparam int NUM_VEC = 4;
  localparam int NUM_RUNS = 2 * NUM_VEC + 3;  // Two table passes plus the extra blocks
  localparam int CYCLE_LIMIT = NUM_RUNS * 200;

  // FIPS-197 appendix B and C.1 then all-zero and all-ones keys
  localparam vec_t VEC_TBL [NUM_VEC] = '{
    '{key: 128'h2b7e151628aed2a6abf7158809cf4f3c,
      ct:  128'h3925841d02dc09fbdc118597196a0b32,
      pt:  128'h3243f6a8885a308d313198a2e0370734},
    '{key: 128'h000102030405060708090a0b0c0d0e0f,
      ct:  128'h69c4e0d86a7b0430d8cdb78070b4c55a,
      pt:  128'h00112233445566778899aabbccddeeff},
    '{key: 128'h00000000000000000000000000000000,
      ct:  128'h66e94bd4ef8a2c3b884cfa59ca342b2e,
      pt:  128'h00000000000000000000000000000000},
    '{key: 128'hffffffffffffffffffffffffffffffff,
      ct:  128'ha1f6258c877d5fcd8964484538bfc92c,
      pt:  128'h00000000000000000000000000000000}
  };

  // SP 800-38A ECB block 1 under the appendix B key
  localparam aes_pkg::block_t EXTRA_CT = 128'h3ad77bb40d7a3660a89ecaf32466ef97;
  localparam aes_pkg::block_t EXTRA_PT = 128'h6bc1bee22e409f96e93d7e117393172a;

  logic               clk;
  logic               rst_n;
  aes_pkg::axil_req_t axil_req;
  aes_pkg::axil_rsp_t axil_rsp;
  logic               bp_en;  // Random bready/rready stretches
  logic [31:0]        lfsr_q;
  int                 errors;
  int                 checks;
  int                 cycle_cnt = 0;

  aes_dec_top aes_dec_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  bind aes_dec_top aes_dec_props props_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, a handshake or status poll never finished", cycle_cnt);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_step();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) lfsr_q = lfsr_q ^ 32'h80200003;
    return b;
  endfunction

  function automatic logic pick_ready();
    logic a;
    logic b;
    if (!bp_en) return 1'b1;
    a = lfsr_step();
    b = lfsr_step();
    return !(a && b);  // Low one cycle in four
  endfunction

  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_word(input string name, input aes_pkg::word_t got,
                            input aes_pkg::word_t exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic write_reg(input aes_pkg::addr_t addr, input aes_pkg::word_t data);
    logic       hs;
    logic [1:0] resp;
    resp = 2'b11;
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    do begin
      @(negedge clk);
      hs = axil_rsp.awready && axil_rsp.wready;
      step_cycle();
    end while (!hs);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    do begin
      axil_req.bready = pick_ready();
      @(negedge clk);
      hs = axil_rsp.bvalid && axil_req.bready;
      if (hs) resp = axil_rsp.bresp;
      step_cycle();
    end while (!hs);
    axil_req.bready = 1'b0;
    check_word("bresp", {30'd0, resp}, {30'd0, aes_pkg::RESP_OKAY});
  endtask

  task automatic read_reg(input aes_pkg::addr_t addr, output aes_pkg::word_t data);
    logic       hs;
    logic [1:0] resp;
    resp = 2'b11;
    data = '0;
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    do begin
      @(negedge clk);
      hs = axil_rsp.arready;
      step_cycle();
    end while (!hs);
    axil_req.arvalid = 1'b0;
    do begin
      axil_req.rready = pick_ready();
      @(negedge clk);
      hs = axil_rsp.rvalid && axil_req.rready;
      if (hs) begin
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
      end
      step_cycle();
    end while (!hs);
    axil_req.rready = 1'b0;
    check_word("rresp", {30'd0, resp}, {30'd0, aes_pkg::RESP_OKAY});
  endtask

  // Poll STATUS until the given bit is set
  task automatic wait_status(input int bit_idx);
    aes_pkg::word_t st;
    do begin
      read_reg(aes_pkg::ADDR_STATUS, st);
    end while (!st[bit_idx]);
  endtask

  task automatic load_key(input aes_pkg::block_t key);
    for (int i = 0; i < 4; i++) begin
      write_reg(aes_pkg::addr_t'(aes_pkg::ADDR_KEY0 + 4 * i), key[127 - 32 * i -: 32]);
    end
    write_reg(aes_pkg::ADDR_CTRL, 32'h2);
    wait_status(1);  // key_ready
  endtask

  task automatic write_block(input aes_pkg::block_t blk);
    for (int i = 0; i < 4; i++) begin
      write_reg(aes_pkg::addr_t'(aes_pkg::ADDR_DIN0 + 4 * i), blk[127 - 32 * i -: 32]);
    end
  endtask

  task automatic start_and_wait();
    write_reg(aes_pkg::ADDR_CTRL, 32'h1);
    wait_status(2);  // done
  endtask

  task automatic check_dout(input aes_pkg::block_t exp);
    aes_pkg::word_t got;
    for (int i = 0; i < 4; i++) begin
      read_reg(aes_pkg::addr_t'(aes_pkg::ADDR_DOUT0 + 4 * i), got);
      check_word($sformatf("dout[%0d]", i), got, exp[127 - 32 * i -: 32]);
    end
  endtask

  initial begin
    aes_pkg::word_t st;
    axil_req = '0;
    rst_n    = 1'b0;
    bp_en    = 1'b0;
    lfsr_q   = 32'h194621a9;
    errors   = 0;
    checks   = 0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    step_cycle();

    read_reg(aes_pkg::ADDR_STATUS, st);
    check_word("status", st, 32'h0);
    check_dout('0);

    // Start with no key loaded is ignored
    write_reg(aes_pkg::ADDR_CTRL, 32'h1);
    repeat (4) step_cycle();
    read_reg(aes_pkg::ADDR_STATUS, st);
    check_word("status", st, 32'h0);

    for (int pass = 0; pass < 2; pass++) begin
      bp_en = (pass == 1);
      for (int v = 0; v < NUM_VEC; v++) begin
        load_key(VEC_TBL[v].key);
        write_block(VEC_TBL[v].ct);
        start_and_wait();
        check_dout(VEC_TBL[v].pt);
      end
    end

    // Back-to-back blocks under one key load
    bp_en = 1'b0;
    load_key(VEC_TBL[0].key);
    write_block(VEC_TBL[0].ct);
    start_and_wait();
    check_dout(VEC_TBL[0].pt);
    write_block(EXTRA_CT);
    start_and_wait();
    check_dout(EXTRA_PT);

    // DIN write lands while the block is in flight
    write_reg(aes_pkg::ADDR_CTRL, 32'h1);
    write_reg(aes_pkg::ADDR_DIN0, VEC_TBL[0].ct[127:96]);
    wait_status(2);
    check_dout(EXTRA_PT);
    read_reg(aes_pkg::ADDR_DIN0, st);
    check_word("din[0]", st, EXTRA_CT[127:96]);

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: flist.f
hw/aes_pkg.sv
hw/aes_axil_regs.sv
hw/aes_dec_ctrl.sv
hw/aes_inv_round.sv
hw/aes_key_sched.sv
hw/aes_dec_top.sv
tb/aes_dec_props.sv
tb/aes_dec_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module aes_dec_tb -f flist.f -o aes_dec_sim \
  && ./obj_dir/aes_dec_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "=== PASS ===" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
